/* verilog/uart_defs.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// default baud timing for the uart_link blocks
// CLK_FREQ / BAUD_RATE must come out at 2 or more
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// system clock in Hz
`define UART_CLK_FREQ  50_000_000

// line rate in bits per second
// the divider is integer only, so keep the ratio close to a whole number
`define UART_BAUD_RATE 115_200

`endif

/* verilog/uart_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// state encodings for the 8N1 transmitter and receiver
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package uart_pkg;

  // transmitter FSM
  typedef enum logic [2:0] {
    tx_idle,         // line high, waiting for go
    tx_start,        // start bit on the line
    tx_data,         // data bits, lsb first
    tx_stop,         // stop bit, line high
    tx_wait_go_low   // frame done, waiting for go to drop
  } tx_state_t;

  // receiver FSM
  typedef enum logic [1:0] {
    rx_idle,   // watching for a falling edge
    rx_start,  // half a bit in, start bit check
    rx_data,   // sampling eight data bits
    rx_stop    // stop bit check
  } rx_state_t;

endpackage

/* verilog/uart_tx.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 transmitter, level go/bsy handshake
// hold data and go until bsy falls, then drop go before the next frame
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_tx #(
  parameter int CLK_FREQ  = `UART_CLK_FREQ,
  parameter int BAUD_RATE = `UART_BAUD_RATE
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] data,  // byte to send, sampled bit by bit
  input  logic       go,    // request, held until bsy falls
  output logic       tx,    // serial line
  output logic       bsy    // high for the whole frame
);

  localparam int BIT_TIME = CLK_FREQ / BAUD_RATE;
  localparam int CNT_W    = $clog2(BIT_TIME);

  if (BIT_TIME < 2) begin : g_bit_time_check
    $error("uart_tx: CLK_FREQ / BAUD_RATE must be at least 2");
  end

  uart_pkg::tx_state_t state;
  logic [CNT_W-1:0]    bit_cnt;  // cycles left in the current bit
  logic [2:0]          bit_idx;  // data bit on the line

  // the first cycle of every bit goes out on the edge that enters it,
  // so each reload is BIT_TIME - 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= uart_pkg::tx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
      bsy     <= 1'b0;
    end else begin
      case (state)
        uart_pkg::tx_idle: begin
          if (go) begin
            tx      <= 1'b0;  // start bit
            bsy     <= 1'b1;
            bit_cnt <= CNT_W'(BIT_TIME - 1);
            state   <= uart_pkg::tx_start;
          end
        end

        uart_pkg::tx_start: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            tx      <= data[0];
            bit_idx <= 3'd0;
            bit_cnt <= CNT_W'(BIT_TIME - 1);
            state   <= uart_pkg::tx_data;
          end
        end

        uart_pkg::tx_data: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= CNT_W'(BIT_TIME - 1);
            if (bit_idx == 3'd7) begin
              tx    <= 1'b1;  // stop bit
              state <= uart_pkg::tx_stop;
            end else begin
              tx      <= data[bit_idx + 3'd1];
              bit_idx <= bit_idx + 3'd1;
            end
          end
        end

        uart_pkg::tx_stop: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bsy   <= 1'b0;  // 10 bit times after it rose
            state <= uart_pkg::tx_wait_go_low;
          end
        end

        uart_pkg::tx_wait_go_low: begin
          if (!go) state <= uart_pkg::tx_idle;  // a held go never restarts
        end

        default: state <= uart_pkg::tx_idle;
      endcase
    end
  end

  // user side must keep the byte steady for the whole frame
  a_data_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    bsy ##1 bsy |-> $stable(data)
  ) else $error("uart_tx: data changed while bsy was high");

  a_idle_not_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    state == uart_pkg::tx_idle |-> !bsy
  ) else $error("uart_tx: bsy high in idle");

endmodule

/* verilog/uart_rx.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 receiver, mid-bit sampling, no stall and no buffering
// a new start edge is needed after a frame error on a held-low line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_rx #(
  parameter int CLK_FREQ  = `UART_CLK_FREQ,
  parameter int BAUD_RATE = `UART_BAUD_RATE
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,         // asynchronous serial line
  output logic [7:0] data,       // last byte, held until the next frame
  output logic       valid,      // one cycle, good stop bit
  output logic       frame_err   // one cycle, stop bit read as 0
);

  localparam int BIT_TIME  = CLK_FREQ / BAUD_RATE;
  localparam int HALF_TIME = BIT_TIME / 2;
  localparam int CNT_W     = $clog2(BIT_TIME);

  if (BIT_TIME < 2) begin : g_bit_time_check
    $error("uart_rx: CLK_FREQ / BAUD_RATE must be at least 2");
  end

  uart_pkg::rx_state_t state;
  logic                rx_meta;   // first synchronizer stage
  logic                rx_sync;   // second stage, safe to use
  logic                rx_prev;   // for the falling edge
  logic [CNT_W-1:0]    bit_cnt;
  logic [2:0]          bit_idx;
  logic                fall;

  // line idles high, so the synchronizer resets to 1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= uart_pkg::rx_idle;
      bit_cnt   <= '0;
      bit_idx   <= '0;
      valid     <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      valid     <= 1'b0;
      frame_err <= 1'b0;
      case (state)
        uart_pkg::rx_idle: begin
          if (fall) begin
            bit_cnt <= CNT_W'(HALF_TIME - 1);  // aim at the middle of the start bit
            state   <= uart_pkg::rx_start;
          end
        end

        uart_pkg::rx_start: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            if (!rx_sync) begin
              bit_cnt <= CNT_W'(BIT_TIME - 1);
              bit_idx <= 3'd0;
              state   <= uart_pkg::rx_data;
            end else begin
              state <= uart_pkg::rx_idle;  // glitch, drop it
            end
          end
        end

        uart_pkg::rx_data: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            bit_cnt <= CNT_W'(BIT_TIME - 1);
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7) state <= uart_pkg::rx_stop;
          end
        end

        uart_pkg::rx_stop: begin
          bit_cnt <= bit_cnt - 1'b1;
          if (bit_cnt == '0) begin
            valid     <= rx_sync;
            frame_err <= !rx_sync;
            state     <= uart_pkg::rx_idle;  // back at mid stop bit
          end
        end

        default: state <= uart_pkg::rx_idle;
      endcase
    end
  end

  // payload shift register, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::rx_data && bit_cnt == '0) begin
      data <= {rx_sync, data[7:1]};
    end
  end

  a_valid_err_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(valid && frame_err)
  ) else $error("uart_rx: valid and frame_err together");

  a_valid_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    valid |=> !valid
  ) else $error("uart_rx: valid longer than one cycle");

  a_err_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    frame_err |=> !frame_err
  ) else $error("uart_rx: frame_err longer than one cycle");

endmodule

/* verilog/uart_link.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8N1 link top, transmitter and receiver run independently
// tx and rx are not tied together here
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_link #(
  parameter int CLK_FREQ  = `UART_CLK_FREQ,
  parameter int BAUD_RATE = `UART_BAUD_RATE
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] tx_data,
  input  logic       tx_go,
  input  logic       rx,
  output logic       tx,
  output logic       tx_bsy,
  output logic [7:0] rx_data,
  output logic       rx_valid,
  output logic       rx_frame_err
);

  uart_tx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_data),
    .go    (tx_go),
    .tx    (tx),
    .bsy   (tx_bsy)
  );

  uart_rx #(.CLK_FREQ(CLK_FREQ), .BAUD_RATE(BAUD_RATE)) u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .data      (rx_data),
    .valid     (rx_valid),
    .frame_err (rx_frame_err)
  );

endmodule

/* bench/uart_link_tb.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for uart_link at 16 clocks per bit
// rx is fed from tx in loopback or from a bench-driven line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module uart_link_tb;

  localparam int CLK_HZ    = 25_000_000;
  localparam int BAUD      = 1_562_500;
  localparam int BIT       = CLK_HZ / BAUD;  // clocks per bit
  localparam int NUM_BYTES = 40;

  logic       clk;
  logic       rst_n;
  logic [7:0] tx_data;
  logic       tx_go;
  logic       bench_rx;   // line driven by the bench
  logic       loop_sel;   // 1 routes tx back to rx
  wire        rx_line;
  logic       tx;
  logic       tx_bsy;
  logic [7:0] rx_data;
  logic       rx_valid;
  logic       rx_frame_err;

  logic [8:0] exp_q[$];   // {frame error expected, byte}
  int         errors;
  int         checks;
  int         bsy_cnt;    // cycles with tx_bsy high in the current frame

  assign rx_line = loop_sel ? tx : bench_rx;

  uart_link #(.CLK_FREQ(CLK_HZ), .BAUD_RATE(BAUD)) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .tx_data      (tx_data),
    .tx_go        (tx_go),
    .rx           (rx_line),
    .tx           (tx),
    .tx_bsy       (tx_bsy),
    .rx_data      (rx_data),
    .rx_valid     (rx_valid),
    .rx_frame_err (rx_frame_err)
  );

  always #20 clk = ~clk;

  // expected line levels with the start bit at index 0
  function automatic logic [9:0] frame_bits(input logic [7:0] b);
    logic [9:0] bits;
    int         i;
    bits[0] = 1'b0;
    for (i = 0; i < 8; i++) begin
      bits[i + 1] = b[i];  // lsb goes out first
    end
    bits[9] = 1'b1;
    return bits;
  endfunction

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic expect_level(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // one rx_valid or rx_frame_err pulse against the head of the queue
  task automatic score_rx_event(input logic is_err);
    logic [8:0] e;
    checks++;
    if (exp_q.size() == 0) begin
      errors++;
      $display("error at %0t ns: unexpected %s pulse with nothing sent", $time,
               is_err ? "rx_frame_err" : "rx_valid");
    end else begin
      e = exp_q.pop_front();
      if (e[8] !== is_err) begin
        errors++;
        $display("error at %0t ns: rx_frame_err got %b expected %b", $time, is_err, e[8]);
      end else if (!is_err && rx_data !== e[7:0]) begin
        errors++;
        $display("error at %0t ns: rx_data got %h expected %h", $time, rx_data, e[7:0]);
      end
    end
  endtask

  // checker samples on the falling edge where everything is settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_valid) score_rx_event(1'b0);
      if (rx_frame_err) score_rx_event(1'b1);
      if (tx_bsy) begin
        bsy_cnt++;
      end else if (bsy_cnt != 0) begin
        checks++;
        if (bsy_cnt != 10 * BIT) begin
          errors++;
          $display("error at %0t ns: tx_bsy length got %0d expected %0d", $time,
                   bsy_cnt, 10 * BIT);
        end
        bsy_cnt = 0;
      end
    end
  end

  task automatic wait_rx_drain(input int limit);
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("timeout at %0t ns: receiver did not report every frame", $time);
      finish_run();
    end
  endtask

  // level handshake and a tx check at the middle of every bit
  task automatic send_byte(input logic [7:0] b, input int hold);
    logic [9:0] bits;
    int         t;
    int         k;
    bits = frame_bits(b);
    @(posedge clk);
    #1;
    tx_data = b;
    tx_go   = 1'b1;
    t = 0;
    @(negedge clk);
    while (tx !== 1'b0 && t < 8) begin
      @(negedge clk);
      t++;
    end
    if (tx !== 1'b0) begin
      errors++;
      $display("timeout at %0t ns: no start bit after tx_go", $time);
      finish_run();
    end
    expect_level("tx_bsy", tx_bsy, 1'b1);  // rises with the start bit
    repeat (BIT / 2) @(negedge clk);
    for (k = 0; k < 10; k++) begin
      expect_level($sformatf("tx bit %0d", k), tx, bits[k]);
      if (k < 9) repeat (BIT) @(negedge clk);
    end
    t = 0;
    while (tx_bsy !== 1'b0 && t < BIT) begin
      @(negedge clk);
      t++;
    end
    if (tx_bsy !== 1'b0) begin
      errors++;
      $display("timeout at %0t ns: tx_bsy never fell", $time);
      finish_run();
    end
    // the line has to stay idle while go is still held
    repeat (hold) begin
      @(negedge clk);
      expect_level("tx", tx, 1'b1);
      expect_level("tx_bsy", tx_bsy, 1'b0);
    end
    @(posedge clk);
    #1 tx_go = 1'b0;
  endtask

  task automatic drive_line(input logic [7:0] b, input logic stop);
    logic [9:0] bits;
    int         k;
    bits    = frame_bits(b);
    bits[9] = stop;
    @(posedge clk);
    #1;
    for (k = 0; k < 10; k++) begin
      bench_rx = bits[k];
      repeat (BIT) @(posedge clk);
      #1;
    end
    bench_rx = 1'b1;
  endtask

  initial begin
    int         i;
    logic [7:0] b;
    clk      = 1'b0;
    rst_n    = 1'b0;
    tx_data  = 8'h00;
    tx_go    = 1'b0;
    bench_rx = 1'b1;
    loop_sel = 1'b0;
    errors   = 0;
    checks   = 0;
    bsy_cnt  = 0;
    void'($urandom(34850));
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    @(negedge clk);
    expect_level("tx", tx, 1'b1);
    expect_level("tx_bsy", tx_bsy, 1'b0);
    expect_level("rx_valid", rx_valid, 1'b0);
    expect_level("rx_frame_err", rx_frame_err, 1'b0);

    // random bytes through tx and back into rx
    @(posedge clk);
    #1 loop_sel = 1'b1;
    for (i = 0; i < NUM_BYTES; i++) begin
      b = $urandom % 256;
      exp_q.push_back({1'b0, b});
      send_byte(b, 0);
    end
    wait_rx_drain(2 * BIT);

    // a held go must not restart but a new go after a drop must
    b = $urandom % 256;
    exp_q.push_back({1'b0, b});
    send_byte(b, 3 * BIT);
    b = $urandom % 256;
    exp_q.push_back({1'b0, b});
    send_byte(b, 0);
    wait_rx_drain(2 * BIT);

    @(posedge clk);
    #1 loop_sel = 1'b0;
    b = $urandom % 256;
    exp_q.push_back({1'b1, b});  // stop bit forced low
    drive_line(b, 1'b0);
    wait_rx_drain(2 * BIT);
    repeat (2 * BIT) @(negedge clk);

    // receiver has to ignore a short low pulse
    @(posedge clk);
    #1 bench_rx = 1'b0;
    repeat (BIT / 4) @(posedge clk);
    #1 bench_rx = 1'b1;
    repeat (12 * BIT) @(negedge clk);
    b = $urandom % 256;
    exp_q.push_back({1'b0, b});
    drive_line(b, 1'b1);
    wait_rx_drain(2 * BIT);

    finish_run();
  end

endmodule

/* uart_link.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_link.sv
bench/uart_link_tb.sv
